// File: src/afferent_pkg.sv
package afferent_pkg;

    // afferent rate in pulses per second, integer
    typedef logic [31:0] rate_t;
    typedef logic [15:0] gain_t;      // q8.8, 256 = 1.0
    typedef logic [31:0] current_t;   // neuron current, integer << 6
    typedef logic [31:0] count_t;     // spike count or time tag

    // per channel settings loaded by the host
    typedef struct packed {
        rate_t offset;                // rate removed before the gain
        gain_t gain;
    } afferent_cfg_t;

    // per channel readback
    typedef struct packed {
        current_t current;            // mixed current fed to the neuron
        count_t   spike_count;
        logic     spike;
    } afferent_obs_t;

    // trigger bus, one bit per loadable register
    localparam int unsigned TRIG_W         = 16;
    localparam int unsigned TRIG_GAIN_IA   = 1;
    localparam int unsigned TRIG_OFFSET_IA = 3;
    localparam int unsigned TRIG_OFFSET_II = 6;
    localparam int unsigned TRIG_DIVIDER   = 7;
    localparam int unsigned TRIG_GAIN_II   = 10;

    localparam int unsigned NOISE_BITS    = 11;   // low current bits taken from the lfsr
    localparam int unsigned CURRENT_SHIFT = 6;    // integer to current format

    // register defaults after reset_global
    localparam rate_t DEF_OFFSET_IA = 32'd70;
    localparam rate_t DEF_OFFSET_II = 32'd50;
    localparam gain_t DEF_GAIN_IA   = 16'd307;    // 1.2
    localparam gain_t DEF_GAIN_II   = 16'd512;    // 2.0

endpackage

// File: src/param_bank.sv
`timescale 1ns/1ps

// host settings; each trigger bit loads the shared data word into its register
module param_bank #(
    parameter afferent_pkg::count_t DIV_DEFAULT = 32'd381   // neuron tick every DIV_DEFAULT + 1 clocks
) (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic [afferent_pkg::TRIG_W-1:0]   i_trig,
    input  logic [31:0]                       i_wire_data,
    output afferent_pkg::afferent_cfg_t       o_cfg_ia,
    output afferent_pkg::afferent_cfg_t       o_cfg_ii,
    output afferent_pkg::count_t              o_div_cnt
);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_cfg_ia.offset <= afferent_pkg::DEF_OFFSET_IA;
            o_cfg_ia.gain   <= afferent_pkg::DEF_GAIN_IA;
            o_cfg_ii.offset <= afferent_pkg::DEF_OFFSET_II;
            o_cfg_ii.gain   <= afferent_pkg::DEF_GAIN_II;
            o_div_cnt       <= DIV_DEFAULT;
        end
        else
        begin
            // several bits may be set, every selected register takes the word
            if (i_trig[afferent_pkg::TRIG_OFFSET_IA])
            begin
                o_cfg_ia.offset <= i_wire_data;
            end
            if (i_trig[afferent_pkg::TRIG_GAIN_IA])
            begin
                o_cfg_ia.gain <= i_wire_data[15:0];   // upper half dropped
            end
            if (i_trig[afferent_pkg::TRIG_OFFSET_II])
            begin
                o_cfg_ii.offset <= i_wire_data;
            end
            if (i_trig[afferent_pkg::TRIG_GAIN_II])
            begin
                o_cfg_ii.gain <= i_wire_data[15:0];
            end
            if (i_trig[afferent_pkg::TRIG_DIVIDER])
            begin
                o_div_cnt <= i_wire_data;             // takes effect at the next compare
            end
        end
    end

endmodule

// File: src/tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
    parameter int unsigned NEURON_STEPS = 128   // neuron ticks per sim tick
) (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  afferent_pkg::count_t  i_div_cnt,
    output logic                  o_neuron_tick,
    output logic                  o_sim_tick,
    output afferent_pkg::count_t  o_time
);

    localparam int unsigned STEP_W = (NEURON_STEPS > 1) ? $clog2(NEURON_STEPS) : 1;
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(NEURON_STEPS - 1);

    afferent_pkg::count_t clk_cnt;    // clocks since the last neuron tick
    logic [STEP_W-1:0]    step_cnt;   // neuron ticks inside one sim tick

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            clk_cnt       <= '0;
            step_cnt      <= '0;
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
            o_time        <= '0;
        end
        else
        begin
            o_neuron_tick <= 1'b0;                   // single cycle pulses
            o_sim_tick    <= 1'b0;
            if (clk_cnt >= i_div_cnt)                // >= so a smaller divider never wraps
            begin
                clk_cnt       <= '0;
                o_neuron_tick <= 1'b1;
                if (step_cnt == STEP_LAST)
                begin
                    step_cnt   <= '0;
                    o_sim_tick <= 1'b1;              // lines up with the last neuron tick
                end
                else
                begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end
            else
            begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            if (o_sim_tick)
            begin
                o_time <= o_time + 1'b1;             // time tag in sim ticks
            end
        end
    end

endmodule

// File: src/afferent_scaler.sv
`timescale 1ns/1ps

// rate to neuron current, one register stage
module afferent_scaler (
    input  logic                         ep50trig,
    input  logic                         reset_global,
    input  afferent_pkg::rate_t          i_rate,
    input  afferent_pkg::afferent_cfg_t  i_cfg,
    output afferent_pkg::current_t       o_current
);

    // integer bits that still fit after the format shift
    localparam int unsigned KEEP_W = 32 - afferent_pkg::CURRENT_SHIFT;
    localparam logic [39:0] SAT_MAX = (40'd1 << KEEP_W) - 40'd1;

    afferent_pkg::rate_t  rate_net;   // rate above offset
    logic [47:0]          product;    // 32 x 16, still q.8
    logic [39:0]          scaled;     // integer part
    logic [KEEP_W-1:0]    sat;

    always_comb
    begin
        // offset removal, clamped so low rates give zero drive
        if (i_rate > i_cfg.offset)
        begin
            rate_net = i_rate - i_cfg.offset;
        end
        else
        begin
            rate_net = '0;
        end
        product = 48'(rate_net) * 48'(i_cfg.gain);
        scaled  = product[47:8];                     // floor of the q8.8 product
        sat     = (scaled > SAT_MAX) ? SAT_MAX[KEEP_W-1:0] : scaled[KEEP_W-1:0];
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_current <= '0;
        end
        else
        begin
            o_current <= {sat, {afferent_pkg::CURRENT_SHIFT{1'b0}}};   // integer << 6
        end
    end

endmodule

// File: src/lif_neuron.sv
`timescale 1ns/1ps

// leaky integrate and fire, membrane moves only on the neuron tick
module lif_neuron #(
    parameter afferent_pkg::current_t THRESHOLD  = 32'd30720,   // 30 mv scaled x1024
    parameter int unsigned            LEAK_SHIFT = 3
) (
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_tick,
    input  afferent_pkg::current_t  i_current,
    output logic                    o_spike
);

    afferent_pkg::current_t v_mem;    // stays below THRESHOLD between ticks
    logic [32:0]            v_next;   // one spare bit, large currents cannot wrap
    logic                   fire;

    always_comb
    begin
        // v - v>>k is never negative, so only the add can grow
        v_next = {1'b0, v_mem} + {1'b0, i_current} - {1'b0, v_mem >> LEAK_SHIFT};
        fire   = (v_next >= {1'b0, THRESHOLD});
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            v_mem   <= '0;
            o_spike <= 1'b0;
        end
        else
        begin
            o_spike <= i_tick & fire;                // one clock wide
            if (i_tick)
            begin
                v_mem <= fire ? '0 : v_next[31:0];   // back to rest after a spike
            end
        end
    end

endmodule

// File: src/afferent_channel.sv
`timescale 1ns/1ps

// scaler, noise, neuron and spike counter for one afferent
module afferent_channel #(
    parameter afferent_pkg::current_t THRESHOLD  = 32'd30720,
    parameter int unsigned            LEAK_SHIFT = 3,
    parameter logic [31:0]            LFSR_SEED  = 32'h1
) (
    input  logic                         ep50trig,
    input  logic                         reset_global,
    input  afferent_pkg::rate_t          i_rate,
    input  afferent_pkg::afferent_cfg_t  i_cfg,
    input  logic                         i_neuron_tick,
    output afferent_pkg::afferent_obs_t  o_obs
);

    afferent_pkg::current_t scaled_current;
    afferent_pkg::current_t mixed_current;
    afferent_pkg::count_t   spike_count;
    logic [31:0]            lfsr;
    logic                   spike;

    afferent_scaler u_scaler (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_rate       (i_rate),
        .i_cfg        (i_cfg),
        .o_current    (scaled_current)
    );

    // noise source, taps 32 22 2 1, one step per neuron tick
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            lfsr <= LFSR_SEED;
        end
        else if (i_neuron_tick)
        begin
            lfsr <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
    end

    // upper bits carry the drive, low bits are dither
    assign mixed_current = {scaled_current[31:afferent_pkg::NOISE_BITS],
                            lfsr[afferent_pkg::NOISE_BITS-1:0]};

    lif_neuron #(
        .THRESHOLD  (THRESHOLD),
        .LEAK_SHIFT (LEAK_SHIFT)
    ) u_neuron (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick       (i_neuron_tick),
        .i_current    (mixed_current),
        .o_spike      (spike)
    );

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            spike_count <= '0;
        end
        else if (spike)
        begin
            spike_count <= spike_count + 1'b1;       // free running, wraps
        end
    end

    assign o_obs = '{current: mixed_current, spike_count: spike_count, spike: spike};

endmodule

// File: src/spindle_afferent_top.sv
`timescale 1ns/1ps

// two afferent channels, Ia and II, sharing the settings bank and tick divider
module spindle_afferent_top #(
    parameter afferent_pkg::count_t   DIV_DEFAULT  = 32'd381,
    parameter int unsigned            NEURON_STEPS = 128,
    parameter afferent_pkg::current_t THRESHOLD    = 32'd30720,
    parameter int unsigned            LEAK_SHIFT   = 3
) (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic [afferent_pkg::TRIG_W-1:0]   i_trig,
    input  logic [31:0]                       i_wire_data,
    input  afferent_pkg::rate_t               i_rate_ia,
    input  afferent_pkg::rate_t               i_rate_ii,
    output afferent_pkg::afferent_obs_t       o_obs_ia,
    output afferent_pkg::afferent_obs_t       o_obs_ii,
    output afferent_pkg::count_t              o_time
);

    afferent_pkg::afferent_cfg_t cfg_ia;
    afferent_pkg::afferent_cfg_t cfg_ii;
    afferent_pkg::count_t        div_cnt;
    logic                        neuron_tick;

    param_bank #(.DIV_DEFAULT(DIV_DEFAULT)) u_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_data  (i_wire_data),
        .o_cfg_ia     (cfg_ia),
        .o_cfg_ii     (cfg_ii),
        .o_div_cnt    (div_cnt)
    );

    // sim tick only feeds the time tag inside the divider
    tick_divider #(.NEURON_STEPS(NEURON_STEPS)) u_div (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_div_cnt     (div_cnt),
        .o_neuron_tick (neuron_tick),
        .o_sim_tick    (),
        .o_time        (o_time)
    );

    afferent_channel #(
        .THRESHOLD  (THRESHOLD),
        .LEAK_SHIFT (LEAK_SHIFT),
        .LFSR_SEED  (32'h5eed_1a01)   // seeds differ so the dither is uncorrelated
    ) u_ch_ia (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_rate        (i_rate_ia),
        .i_cfg         (cfg_ia),
        .i_neuron_tick (neuron_tick),
        .o_obs         (o_obs_ia)
    );

    afferent_channel #(
        .THRESHOLD  (THRESHOLD),
        .LEAK_SHIFT (LEAK_SHIFT),
        .LFSR_SEED  (32'h0c3a_9b27)
    ) u_ch_ii (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_rate        (i_rate_ii),
        .i_cfg         (cfg_ii),
        .i_neuron_tick (neuron_tick),
        .o_obs         (o_obs_ii)
    );

endmodule

// File: test/spindle_afferent_sva.sv
`timescale 1ns/1ps

// protocol checks on the top level outputs
module spindle_afferent_sva (
    input logic                        ep50trig,
    input logic                        reset_global,
    input afferent_pkg::afferent_obs_t o_obs_ia,
    input afferent_pkg::afferent_obs_t o_obs_ii,
    input afferent_pkg::count_t        o_time
);

    int sva_errors = 0;                   // assertion failures so far

    // spike is a single clock pulse
    spike_ia_pulse: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_obs_ia.spike |=> !o_obs_ia.spike)
    else
    begin
        $error("ia spike held high for two cycles");
        sva_errors++;
    end
    spike_ii_pulse: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_obs_ii.spike |=> !o_obs_ii.spike)
    else
    begin
        $error("ii spike held high for two cycles");
        sva_errors++;
    end

    // counter moves only one cycle after a spike
    count_ia_cause: assert property (@(posedge ep50trig) disable iff (reset_global)
        (o_obs_ia.spike_count != $past(o_obs_ia.spike_count)) |-> $past(o_obs_ia.spike))
    else
    begin
        $error("ia spike count changed without a spike");
        sva_errors++;
    end
    count_ii_cause: assert property (@(posedge ep50trig) disable iff (reset_global)
        (o_obs_ii.spike_count != $past(o_obs_ii.spike_count)) |-> $past(o_obs_ii.spike))
    else
    begin
        $error("ii spike count changed without a spike");
        sva_errors++;
    end

    // time tag holds or steps by one
    time_step: assert property (@(posedge ep50trig) disable iff (reset_global)
        (o_time == $past(o_time)) || (o_time == $past(o_time) + 32'd1))
    else
    begin
        $error("time tag jumped by more than one");
        sva_errors++;
    end

endmodule

bind spindle_afferent_top spindle_afferent_sva u_sva (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .o_obs_ia     (o_obs_ia),
    .o_obs_ii     (o_obs_ii),
    .o_time       (o_time)
);

// File: test/tb_spindle_afferent.sv
`timescale 1ns/1ps

module tb_spindle_afferent;

    localparam int unsigned DIV_DEF    = 1;        // neuron tick every 2 clocks
    localparam int unsigned STEPS      = 4;        // neuron ticks per sim tick
    localparam int unsigned SETTLE     = 8;        // cycles from stimulus to check
    localparam int unsigned TIME_WIN   = 64;       // cycles for the time rate check
    localparam int unsigned QUIET_WIN  = 40;       // cycles without spikes
    localparam int unsigned SPIKE_SIMS = 3;        // sim ticks in the spike rate window
    localparam int          SPK_ANY    = 0;
    localparam int          SPK_NONE   = 1;
    localparam int          SPK_EVERY  = 2;
    localparam afferent_pkg::current_t UPPER = ~((32'd1 << afferent_pkg::NOISE_BITS) - 32'd1);

    logic                         ep50trig;
    logic                         reset_global;
    logic [afferent_pkg::TRIG_W-1:0] i_trig;
    logic [31:0]                  i_wire_data;
    afferent_pkg::rate_t          i_rate_ia;
    afferent_pkg::rate_t          i_rate_ii;
    afferent_pkg::afferent_obs_t  o_obs_ia;
    afferent_pkg::afferent_obs_t  o_obs_ii;
    afferent_pkg::count_t         o_time;

    // stimulus table, one column per array
    string                  names [16];
    logic [15:0]            trigs [16];
    logic [31:0]            datas [16];
    afferent_pkg::rate_t    rates_ia [16];
    afferent_pkg::rate_t    rates_ii [16];
    afferent_pkg::current_t exp_ia [16];
    afferent_pkg::current_t exp_ii [16];
    int                     spk_ia [16];
    int                     spk_ii [16];
    afferent_pkg::count_t   exp_time [16];
    int                     n_entries = 0;

    // expected register contents, follow the trigger writes
    afferent_pkg::rate_t    sh_off_ia  = afferent_pkg::DEF_OFFSET_IA;
    afferent_pkg::rate_t    sh_off_ii  = afferent_pkg::DEF_OFFSET_II;
    afferent_pkg::gain_t    sh_gain_ia = afferent_pkg::DEF_GAIN_IA;
    afferent_pkg::gain_t    sh_gain_ii = afferent_pkg::DEF_GAIN_II;
    int unsigned            sh_div     = DIV_DEF;

    logic [31:0] rng = 32'hada4a9af;                 // stimulus lfsr state
    int          cur_errors = 0;
    int          cnt_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 4 + 100;              // reset plus margin, entries add on

    spindle_afferent_top #(
        .DIV_DEFAULT  (DIV_DEF),
        .NEURON_STEPS (STEPS),
        .THRESHOLD    (32'd30720),
        .LEAK_SHIFT   (3)
    ) uut (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_data  (i_wire_data),
        .i_rate_ia    (i_rate_ia),
        .i_rate_ii    (i_rate_ii),
        .o_obs_ia     (o_obs_ia),
        .o_obs_ii     (o_obs_ii),
        .o_time       (o_time)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #20 ep50trig = ~ep50trig;            // 40 ns period
    end

    // fibonacci lfsr, taps 32 31 30 10, one step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            fb  = rng[31] ^ rng[30] ^ rng[29] ^ rng[9];
            rng = {rng[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // rate minus offset clamped at zero, q8.8 gain, floor, saturate to 26 bits, times 64
    function automatic afferent_pkg::current_t model_current(
        input afferent_pkg::rate_t rate, input afferent_pkg::rate_t off,
        input afferent_pkg::gain_t gain);
        longint unsigned net;
        longint unsigned whole;
        net   = (rate > off) ? (rate - off) : 0;
        whole = (net * gain) / 256;
        if (whole > 64'h3ff_ffff)
        begin
            whole = 64'h3ff_ffff;                    // largest value that survives the shift
        end
        return afferent_pkg::current_t'(whole * 64);
    endfunction

    task automatic add_entry(input string name, input logic [15:0] trig, input logic [31:0] data,
                             input afferent_pkg::rate_t r_ia, input afferent_pkg::rate_t r_ii,
                             input int s_ia, input int s_ii);
        if (trig[afferent_pkg::TRIG_OFFSET_IA]) sh_off_ia = data;
        if (trig[afferent_pkg::TRIG_GAIN_IA])   sh_gain_ia = data[15:0];
        if (trig[afferent_pkg::TRIG_OFFSET_II]) sh_off_ii = data;
        if (trig[afferent_pkg::TRIG_GAIN_II])   sh_gain_ii = data[15:0];
        if (trig[afferent_pkg::TRIG_DIVIDER])   sh_div = data;
        names[n_entries]    = name;
        trigs[n_entries]    = trig;
        datas[n_entries]    = data;
        rates_ia[n_entries] = r_ia;
        rates_ii[n_entries] = r_ii;
        exp_ia[n_entries]   = model_current(r_ia, sh_off_ia, sh_gain_ia) & UPPER;
        exp_ii[n_entries]   = model_current(r_ii, sh_off_ii, sh_gain_ii) & UPPER;
        spk_ia[n_entries]   = s_ia;
        spk_ii[n_entries]   = s_ii;
        exp_time[n_entries] = TIME_WIN / ((sh_div + 1) * STEPS);   // sim ticks per window
        cycle_limit += 3 + SETTLE + TIME_WIN + QUIET_WIN + (SPIKE_SIMS + 2) * (sh_div + 1) * STEPS;
        n_entries++;
    endtask

    task automatic build_table();
        add_entry("reset_defaults", 16'h0, 32'h0, 32'd200, 32'd150, SPK_ANY, SPK_ANY);
        add_entry("offset_clamp", 16'h0, 32'h0, rand_bits(6), rand_bits(5), SPK_NONE, SPK_NONE);
        add_entry("write_offset_ia", 16'h1 << afferent_pkg::TRIG_OFFSET_IA, 32'd20,
                  32'd200, 32'd150, SPK_ANY, SPK_ANY);
        add_entry("write_gain_ii", 16'h1 << afferent_pkg::TRIG_GAIN_II, 32'habcd_0180,
                  32'd100 + rand_bits(7), 32'd60 + rand_bits(7), SPK_ANY, SPK_ANY);
        add_entry("gain_ia_low_half", 16'h1 << afferent_pkg::TRIG_GAIN_IA, 32'h5a5a_0100,
                  32'd100 + rand_bits(7), 32'd150, SPK_ANY, SPK_ANY);
        add_entry("both_offsets", (16'h1 << afferent_pkg::TRIG_OFFSET_IA) |
                  (16'h1 << afferent_pkg::TRIG_OFFSET_II), 32'd90,
                  rand_bits(6), 32'd300, SPK_NONE, SPK_ANY);
        add_entry("saturation", 16'h0, 32'h0, 32'hffff_ffff, 32'hffff_ffff, SPK_EVERY, SPK_EVERY);
        // net rate of 480 after gain reaches the threshold exactly
        add_entry("strong_drive", 16'h0, 32'h0, 32'd570 + rand_bits(8), 32'd410 + rand_bits(8),
                  SPK_EVERY, SPK_EVERY);
        add_entry("divider_write", 16'h1 << afferent_pkg::TRIG_DIVIDER, 32'd3,
                  32'd0, 32'd0, SPK_NONE, SPK_NONE);
        add_entry("slow_strong", 16'h0, 32'h0, 32'd600, 32'd500, SPK_EVERY, SPK_EVERY);
    endtask

    task automatic check_current(input string name, input afferent_pkg::current_t exp,
                                 input afferent_pkg::current_t act);
        if (exp !== act)
        begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            cur_errors++;
        end
    endtask

    task automatic check_count(input string name, input afferent_pkg::count_t exp,
                               input afferent_pkg::count_t act, input int unsigned tol);
        afferent_pkg::count_t diff;
        diff = (act > exp) ? act - exp : exp - act;
        if ($isunknown(act) || diff > tol)
        begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            cnt_errors++;
        end
    endtask

    // count window aligned to time tag steps, so both ends see the same phase
    task automatic spike_rate(input string name, input int k);
        afferent_pkg::count_t t0;
        afferent_pkg::count_t c_ia;
        afferent_pkg::count_t c_ii;
        t0 = o_time;
        while (o_time == t0) @(negedge ep50trig);
        t0   = o_time;
        c_ia = o_obs_ia.spike_count;
        c_ii = o_obs_ii.spike_count;
        while (o_time != t0 + SPIKE_SIMS) @(negedge ep50trig);
        if (spk_ia[k] == SPK_EVERY)
            check_count({name, "_ia_spikes"}, SPIKE_SIMS * STEPS, o_obs_ia.spike_count - c_ia, 1);
        if (spk_ii[k] == SPK_EVERY)
            check_count({name, "_ii_spikes"}, SPIKE_SIMS * STEPS, o_obs_ii.spike_count - c_ii, 1);
    endtask

    task automatic run_entry(input int k);
        afferent_pkg::count_t t0;
        afferent_pkg::count_t c_ia;
        afferent_pkg::count_t c_ii;
        @(posedge ep50trig);
        i_trig      <= trigs[k];
        i_wire_data <= datas[k];
        i_rate_ia   <= rates_ia[k];
        i_rate_ii   <= rates_ii[k];
        @(posedge ep50trig);
        i_trig <= '0;                                // one cycle trigger strobe
        repeat (SETTLE) @(posedge ep50trig);
        @(negedge ep50trig);                         // outputs settled mid cycle
        check_current({names[k], "_ia_current"}, exp_ia[k], o_obs_ia.current & UPPER);
        check_current({names[k], "_ii_current"}, exp_ii[k], o_obs_ii.current & UPPER);
        t0 = o_time;
        repeat (TIME_WIN) @(negedge ep50trig);
        check_count({names[k], "_time"}, exp_time[k], o_time - t0, 1);
        c_ia = o_obs_ia.spike_count;
        c_ii = o_obs_ii.spike_count;
        repeat (QUIET_WIN) @(negedge ep50trig);
        if (spk_ia[k] == SPK_NONE)
            check_count({names[k], "_ia_quiet"}, 0, o_obs_ia.spike_count - c_ia, 0);
        if (spk_ii[k] == SPK_NONE)
            check_count({names[k], "_ii_quiet"}, 0, o_obs_ii.spike_count - c_ii, 0);
        if (spk_ia[k] == SPK_EVERY || spk_ii[k] == SPK_EVERY)
            spike_rate(names[k], k);
    endtask

    // run length guard
    always @(posedge ep50trig)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: no end of test after %0d clock cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin : main_seq
        int k;
        i_trig       = '0;
        i_wire_data  = '0;
        i_rate_ia    = '0;
        i_rate_ii    = '0;
        reset_global = 1'b1;
        build_table();
        repeat (4) @(posedge ep50trig);
        reset_global <= 1'b0;
        for (k = 0; k < n_entries; k++)
        begin
            run_entry(k);
        end
        $display("errors: %0d current, %0d count, %0d assertion, %0d total", cur_errors,
                 cnt_errors, uut.u_sva.sva_errors,
                 cur_errors + cnt_errors + uut.u_sva.sva_errors);
        if (cur_errors + cnt_errors + uut.u_sva.sva_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
src/afferent_pkg.sv
src/param_bank.sv
src/tick_divider.sv
src/afferent_scaler.sv
src/lif_neuron.sv
src/afferent_channel.sv
src/spindle_afferent_top.sv
test/spindle_afferent_sva.sv
test/tb_spindle_afferent.sv

// File: Bender.yml
package:
  name: spindle_afferent

sources:
  - src/afferent_pkg.sv
  - src/param_bank.sv
  - src/tick_divider.sv
  - src/afferent_scaler.sv
  - src/lif_neuron.sv
  - src/afferent_channel.sv
  - src/spindle_afferent_top.sv
  - target: test
    files:
      - test/spindle_afferent_sva.sv
      - test/tb_spindle_afferent.sv
